// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := mipsTb
FILELIST   := sim.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
+incdir+verilog
verilog/mipsIsaPkg.sv
verilog/pipePkg.sv
verilog/fetchStage.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memWriteback.sv
verilog/mips.sv
verif/mipsTb.sv

// ==== verif/mipsTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module mipsTb import mipsIsaPkg::*; ();

    localparam int ResetCycles    = 3;
    localparam int DrainCycles    = 8;   // pipeline depth plus margin
    localparam int CyclesPerInstr = 40;
    localparam int ImemWords      = 64;
    localparam int DmemWords      = 256;

    logic    clk = 1'b0;
    logic    rstN;
    wordT    instrAddr, instrData, dataAddr, dataWdata, dataRdata;
    logic    dataWe, wbWe;
    regAddrT wbAddr;
    wordT    wbData, wbPc;

    wordT    imem [ImemWords];
    wordT    dmem [DmemWords];
    wordT    modelMem [DmemWords];
    wordT    modelReg [32];
    int      progLen;

    // reference trace matched in order
    wordT    expPc[$], expData[$], expStAddr[$], expStData[$];
    regAddrT expAddr[$];
    opcodeT  expOp[$];
    int      traceIdx, storeIdx;

    int      errors, testErrors, testsRun, testsFailed;
    string   curTest = "reset";
    integer  seed = 32'h4aff;
    int      cycleCount;
    int      cycleLimit = 2 * ResetCycles;

    mips uut (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
        .dataRdata(dataRdata), .wbWe(wbWe), .wbAddr(wbAddr), .wbData(wbData),
        .wbPc(wbPc)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // memory models driven 1 ns after the edge
    ////////////////////////////////////////////////////////////
    function automatic wordT fetchWord(input wordT addr);
        wordT offs;
        offs = (addr - `RESET_PC) >> 2;
        if (offs < ImemWords) return imem[offs[5:0]];
        return `NOP_INSTR;  // outside the program
    endfunction

    initial begin
        instrData = `NOP_INSTR;
        dataRdata = '0;
        forever begin
            @(posedge clk);
            #1;
            instrData = fetchWord(instrAddr);
            dataRdata = dmem[dataAddr[9:2]];
        end
    end

    initial begin
        cycleCount = 0;
        do begin
            @(posedge clk);
            cycleCount++;
        end while (cycleCount < cycleLimit);
        $display("timeout: pipeline made no progress after %0d cycles in test %s",
                 cycleCount, curTest);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic noteError();
        errors++;
        testErrors++;
    endtask

    task automatic checkWord(input string what, input wordT exp, input wordT act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", curTest, what, exp, act);
            noteError();
        end
    endtask

    task automatic checkReg(input string what, input regAddrT exp, input regAddrT act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", curTest, what, exp, act);
            noteError();
        end
    endtask

    task automatic checkOp(input string what, input opcodeT exp, input opcodeT act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", curTest, what, exp, act);
            noteError();
        end
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", curTest, what, exp, act);
            noteError();
        end
    endtask

    task automatic checkTrace();
        wordT idx;
        if (traceIdx >= expPc.size()) begin
            $display("unexpected register write to $%0d at pc %h in test %s",
                     wbAddr, wbPc, curTest);
            noteError();
        end else begin
            checkWord($sformatf("wbPc #%0d", traceIdx), expPc[traceIdx], wbPc);
            checkReg($sformatf("wbAddr #%0d", traceIdx), expAddr[traceIdx], wbAddr);
            checkWord($sformatf("wbData #%0d", traceIdx), expData[traceIdx], wbData);
            idx = (wbPc - `RESET_PC) >> 2;
            checkOp($sformatf("opcode #%0d", traceIdx), expOp[traceIdx],
                    opcodeT'(imem[idx[5:0]][31:26]));
        end
        traceIdx++;
    endtask

    task automatic checkStore();
        if (storeIdx >= expStAddr.size()) begin
            $display("unexpected store to %h in test %s", dataAddr, curTest);
            noteError();
        end else begin
            checkWord($sformatf("dataAddr #%0d", storeIdx), expStAddr[storeIdx], dataAddr);
            checkWord($sformatf("dataWdata #%0d", storeIdx), expStData[storeIdx], dataWdata);
        end
        dmem[dataAddr[9:2]] = dataWdata;  // commit
        storeIdx++;
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rstN) begin
            checkFlag("wbWe in reset", 1'b0, wbWe);
            checkFlag("dataWe in reset", 1'b0, dataWe);
        end else begin
            if (wbWe) checkTrace();
            if (dataWe) checkStore();
        end
    end

    ////////////////////////////////////////////////////////////
    // program building and reference model
    ////////////////////////////////////////////////////////////
    function automatic wordT encR(input functT fn, input int rd, input int rs, input int rt);
        return {opSpecial, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    // operands in assembly order with rt first
    function automatic wordT encI(input opcodeT op, input int rt, input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic int randImm();
        int r;
        r = $random(seed);
        return r & 32'hffff;
    endfunction

    task automatic addInstr(input wordT w);
        imem[progLen[5:0]] = w;
        progLen++;
    endtask

    task automatic runModel();
        wordT    pc, npc, nnpc, ins, a, b, val, addr, idx;
        regAddrT dst;
        logic    wr;
        int      steps;
        for (int i = 0; i < 32; i++) modelReg[i[4:0]] = '0;
        pc    = `RESET_PC;
        npc   = pc + 32'd4;
        steps = 0;
        idx   = '0;
        while (idx < progLen && steps < 4 * ImemWords) begin
            ins  = imem[idx[5:0]];
            a    = modelReg[ins[25:21]];
            b    = modelReg[ins[20:16]];
            addr = a + {{16{ins[15]}}, ins[15:0]};
            nnpc = npc + 32'd4;  // delay slot always runs
            wr   = 1'b1;
            dst  = ins[20:16];
            val  = '0;
            case (ins[31:26])
                opSpecial: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        fnAddu:  val = a + b;
                        fnSubu:  val = a - b;
                        fnAnd:   val = a & b;
                        fnOr:    val = a | b;
                        fnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opOri: val = a | {16'h0000, ins[15:0]};
                opLui: val = {ins[15:0], 16'h0000};
                opLw:  val = modelMem[addr[9:2]];
                opSw: begin
                    wr = 1'b0;
                    modelMem[addr[9:2]] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                end
                opBeq: begin
                    wr = 1'b0;
                    if (a == b) nnpc = npc + {{14{ins[15]}}, ins[15:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                expPc.push_back(pc);
                expAddr.push_back(dst);
                expData.push_back(val);
                expOp.push_back(opcodeT'(ins[31:26]));
                if (dst != '0) modelReg[dst] = val;  // $0 stays zero
            end
            pc  = npc;
            npc = nnpc;
            idx = (pc - `RESET_PC) >> 2;
            steps++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequencing
    ////////////////////////////////////////////////////////////
    task automatic startTest(input string name);
        @(posedge clk);
        #1;
        rstN = 1'b0;
        curTest    = name;
        testErrors = 0;
        progLen    = 0;
        traceIdx   = 0;
        storeIdx   = 0;
        for (int i = 0; i < ImemWords; i++) imem[i[5:0]] = `NOP_INSTR;
        for (int i = 0; i < DmemWords; i++) begin
            dmem[i[7:0]]     = (i << 2) ^ 32'hc3a5_5a3c;  // differs per address
            modelMem[i[7:0]] = dmem[i[7:0]];
        end
        expPc.delete();
        expAddr.delete();
        expData.delete();
        expOp.delete();
        expStAddr.delete();
        expStData.delete();
    endtask

    task automatic launchProgram();
        runModel();
        cycleLimit += CyclesPerInstr * progLen + ResetCycles + DrainCycles + 2;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkWord("instrAddr after reset", `RESET_PC, instrAddr);
    endtask

    task automatic finishProgram();
        while (traceIdx < expPc.size() || storeIdx < expStAddr.size()) begin
            @(posedge clk);
        end
        repeat (DrainCycles) @(posedge clk);  // catch stray writes
        testsRun++;
        if (testErrors == 0) begin
            $display("test %s: ok, %0d writes, %0d stores", curTest, traceIdx, storeIdx);
        end else begin
            $display("test %s: %0d errors", curTest, testErrors);
            testsFailed++;
        end
    endtask

    task automatic testResetState();
        startTest("resetState");
        addInstr(encI(opOri, 1, 0, randImm()));
        addInstr(encI(opSw, 1, 0, 16'h20));
        addInstr(encI(opLw, 2, 0, 16'h20));
        addInstr(encR(fnAddu, 3, 2, 1));
        launchProgram();
        repeat (4) begin  // nothing reaches W before this
            @(negedge clk);
            checkFlag("early wbWe", 1'b0, wbWe);
            checkFlag("early dataWe", 1'b0, dataWe);
        end
        finishProgram();
    endtask

    task automatic testAluChain();
        startTest("aluChain");
        addInstr(encI(opLui, 1, 0, randImm()));
        addInstr(encI(opOri, 1, 1, randImm()));  // lui forwarded from E
        addInstr(encI(opOri, 2, 0, randImm()));
        addInstr(encR(fnAddu, 3, 1, 2));
        addInstr(encR(fnSubu, 4, 3, 1));
        addInstr(encR(fnAnd, 5, 4, 3));
        addInstr(encR(fnOr, 6, 5, 2));
        addInstr(encR(fnSlt, 7, 4, 3));
        addInstr(encR(fnSlt, 8, 3, 4));
        addInstr(encI(opLui, 9, 0, randImm()));
        addInstr(encR(fnAddu, 10, 9, 9));
        launchProgram();
        finishProgram();
    endtask

    task automatic testLoadUse();
        startTest("loadUse");
        addInstr(encI(opOri, 1, 0, 16'h40));
        addInstr(encI(opLw, 2, 1, 0));
        addInstr(encR(fnAddu, 3, 2, 1));  // load-use stall
        addInstr(encI(opLw, 4, 1, 4));
        addInstr(encI(opLw, 5, 1, 8));
        addInstr(encR(fnSubu, 6, 5, 4));
        addInstr(encR(fnOr, 7, 6, 2));
        addInstr(encI(opLw, 8, 1, 16'h0c));
        addInstr(encI(opBeq, 2, 8, 1));   // waits for the load in M
        addInstr(encI(opOri, 9, 0, randImm()));
        addInstr(encI(opOri, 10, 0, randImm()));
        launchProgram();
        finishProgram();
    endtask

    task automatic testStoreLoad();
        startTest("storeLoad");
        addInstr(encI(opOri, 1, 0, 16'h80));
        addInstr(encI(opOri, 2, 0, randImm()));
        addInstr(encI(opSw, 2, 1, 0));    // data from the previous ori
        addInstr(encI(opLw, 3, 1, 0));
        addInstr(encR(fnAddu, 4, 3, 3));
        addInstr(encI(opLui, 5, 0, randImm()));
        addInstr(encI(opSw, 5, 1, 4));
        addInstr(encI(opLw, 6, 1, 4));
        addInstr(encI(opLw, 7, 1, 0));
        addInstr(encI(opSw, 7, 1, 8));    // fixed up from W in M
        addInstr(encI(opLw, 8, 1, 8));
        launchProgram();
        finishProgram();
    endtask

    task automatic testBranch();
        startTest("branch");
        addInstr(encI(opOri, 1, 0, 5));
        addInstr(encI(opOri, 2, 0, 5));
        addInstr(encI(opBeq, 2, 1, 2));   // taken to index 5
        addInstr(encI(opOri, 3, 0, 1));   // delay slot
        addInstr(encI(opOri, 4, 0, 2));   // skipped
        addInstr(encI(opOri, 5, 0, 3));
        addInstr(encI(opBeq, 3, 1, 2));   // not taken
        addInstr(encI(opOri, 6, 0, 4));
        addInstr(encI(opOri, 7, 0, 6));
        addInstr(encI(opBeq, 0, 0, 2));   // taken to index 12
        addInstr(encR(fnAddu, 8, 1, 2));
        addInstr(encI(opOri, 9, 0, 7));   // skipped
        addInstr(encR(fnSubu, 10, 8, 1));
        launchProgram();
        finishProgram();
    endtask

    task automatic testZeroReg();
        startTest("zeroReg");
        addInstr(encI(opOri, 0, 0, randImm()));
        addInstr(encR(fnAddu, 1, 0, 0));
        addInstr(encI(opOri, 0, 0, randImm()));
        addInstr(encR(fnOr, 2, 0, 1));
        addInstr(encI(opLui, 0, 0, randImm()));
        addInstr(encR(fnAddu, 3, 0, 0));
        addInstr(encI(opLw, 0, 0, 16'h10));
        addInstr(encR(fnAddu, 4, 0, 0));
        addInstr(encI(opSw, 0, 0, 16'h14));
        launchProgram();
        finishProgram();
    endtask

    initial begin
        rstN = 1'b0;
        testResetState();
        testAluChain();
        testLoadUse();
        testStoreLoad();
        testBranch();
        testZeroReg();
        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module executeStage import mipsIsaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    stall,
    input  wordT    dInstr,
    input  wordT    dPc,
    input  wordT    rdDataA,
    input  wordT    rdDataB,
    input  fwdSelT  dFwdRs,
    input  fwdSelT  dFwdRt,
    input  fwdSelT  eFwdRs,
    input  fwdSelT  eFwdRt,
    input  wordT    mFwdData,
    input  wordT    wFwdData,
    output logic    branchTaken,
    output wordT    branchTarget,
    output regAddrT dRs,
    output regAddrT dRt,
    output regAddrT eRs,
    output regAddrT eRt,
    output regAddrT eDest,
    output hazTimeT dUseRs,
    output hazTimeT dUseRt,
    output hazTimeT eNew,
    output wordT    mInstr,
    output wordT    mPc,
    output wordT    mAlu,
    output wordT    mStoreData
);

    logic [15:0] dImm, eImm;
    logic        dIsBeq, eUseImm;
    wordT        dRsVal, dRtVal, eInstr, ePc, eRsReg, eRtReg;
    wordT        eRsVal, eRtVal, eExt, eFwdData, aluB, aluOut;
    aluOpT       eAluOp;
    wdSrcT       eWdSrc;

    function automatic wordT pickOperand(input fwdSelT sel, input wordT regVal,
                                         input wordT eVal, input wordT mVal,
                                         input wordT wVal);
        case (sel)
            fwdFromE: return eVal;
            fwdFromM: return mVal;
            fwdFromW: return wVal;
            default:  return regVal;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // decode side, beq resolves here
    ////////////////////////////////////////////////////////////
    instrDecoder dDec (
        .instr(dInstr), .rs(dRs), .rt(dRt), .dest(), .imm(dImm), .aluOp(),
        .useImm(), .wdSrc(), .isBeq(dIsBeq), .isStore(), .useRs(dUseRs),
        .useRt(dUseRt), .newTime()
    );

    assign dRsVal = pickOperand(dFwdRs, rdDataA, eFwdData, mFwdData, wFwdData);
    assign dRtVal = pickOperand(dFwdRt, rdDataB, eFwdData, mFwdData, wFwdData);

    assign branchTaken  = dIsBeq && (dRsVal == dRtVal);
    assign branchTarget = dPc + 32'd4 + {{14{dImm[15]}}, dImm, 2'b00};

    // D/E register, bubble on stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            eInstr <= `NOP_INSTR;
            ePc    <= '0;
        end else begin
            eInstr <= stall ? `NOP_INSTR : dInstr;
            ePc    <= stall ? '0 : dPc;
        end
    end

    always_ff @(posedge clk) begin
        eRsReg <= dRsVal;
        eRtReg <= dRtVal;
    end

    ////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////
    instrDecoder eDec (
        .instr(eInstr), .rs(eRs), .rt(eRt), .dest(eDest), .imm(eImm), .aluOp(eAluOp),
        .useImm(eUseImm), .wdSrc(eWdSrc), .isBeq(), .isStore(), .useRs(),
        .useRt(), .newTime(eNew)
    );

    // lui upper half, ori zero-extends, lw/sw sign-extend
    assign eExt = (eAluOp == aluPassB) ? {eImm, 16'h0000} :
                  (eAluOp == aluOr)    ? {16'h0000, eImm} :
                                         {{16{eImm[15]}}, eImm};
    assign eFwdData = (eWdSrc == wdExt) ? eExt : '0;  // only lui is ready in E

    assign eRsVal = pickOperand(eFwdRs, eRsReg, eFwdData, mFwdData, wFwdData);
    assign eRtVal = pickOperand(eFwdRt, eRtReg, eFwdData, mFwdData, wFwdData);
    assign aluB   = eUseImm ? eExt : eRtVal;

    always_comb begin
        case (eAluOp)
            aluSub:   aluOut = eRsVal - aluB;
            aluAnd:   aluOut = eRsVal & aluB;
            aluOr:    aluOut = eRsVal | aluB;
            aluSlt:   aluOut = {31'd0, $signed(eRsVal) < $signed(aluB)};
            aluPassB: aluOut = aluB;
            default:  aluOut = eRsVal + aluB;
        endcase
    end

    // E/M register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mInstr <= `NOP_INSTR;
            mPc    <= '0;
        end else begin
            mInstr <= eInstr;
            mPc    <= ePc;
        end
    end

    always_ff @(posedge clk) begin
        mAlu       <= aluOut;
        mStoreData <= eRtVal;  // may still be fixed up from W in M
    end

endmodule

`default_nettype wire

// ==== verilog/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module fetchStage import mipsIsaPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic branchTaken,
    input  wordT branchTarget,
    input  wordT instrData,
    output wordT instrAddr,
    output wordT dInstr,
    output wordT dPc
);

    wordT pc;
    wordT nextPc;

    // beq resolves in D, the slot after it is already being fetched
    assign nextPc = branchTaken ? branchTarget : pc + 32'd4;
    assign instrAddr = pc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    ////////////////////////////////////////////////////////////
    // F/D register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dInstr <= `NOP_INSTR;
            dPc    <= '0;
        end else if (!stall) begin
            dInstr <= instrData;  // held, not cleared, on stall
            dPc    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module hazardUnit import mipsIsaPkg::*, pipePkg::*; (
    input  regAddrT dRs,
    input  regAddrT dRt,
    input  hazTimeT dUseRs,
    input  hazTimeT dUseRt,
    input  regAddrT eDest,
    input  regAddrT mDest,
    input  regAddrT wDest,
    input  hazTimeT eNew,
    input  hazTimeT mNew,
    input  regAddrT eRs,
    input  regAddrT eRt,
    output logic    stall,
    output fwdSelT  dFwdRs,
    output fwdSelT  dFwdRt,
    output fwdSelT  eFwdRs,
    output fwdSelT  eFwdRt
);

    // operand not ready in time, nearest producer decides
    function automatic logic srcStall(input regAddrT src, input hazTimeT useT);
        if (src == '0)        return 1'b0;
        else if (src == eDest) return useT < eNew;
        else if (src == mDest) return useT < mNew;
        else                   return 1'b0;
    endfunction

    function automatic fwdSelT dSel(input regAddrT src);
        if (src == '0)         return fwdReg;
        else if (src == eDest) return fwdFromE;
        else if (src == mDest) return fwdFromM;
        else                   return fwdReg;  // W covered by regFile bypass
    endfunction

    function automatic fwdSelT eSel(input regAddrT src);
        if (src == '0)         return fwdReg;
        else if (src == mDest) return fwdFromM;
        else if (src == wDest) return fwdFromW;
        else                   return fwdReg;
    endfunction

    assign stall  = srcStall(dRs, dUseRs) | srcStall(dRt, dUseRt);
    assign dFwdRs = dSel(dRs);
    assign dFwdRt = dSel(dRt);
    assign eFwdRs = eSel(eRs);
    assign eFwdRt = eSel(eRt);

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module instrDecoder import mipsIsaPkg::*, pipePkg::*; (
    input  wordT        instr,
    output regAddrT     rs,
    output regAddrT     rt,
    output regAddrT     dest,
    output logic [15:0] imm,
    output aluOpT       aluOp,
    output logic        useImm,
    output wdSrcT       wdSrc,
    output logic        isBeq,
    output logic        isStore,
    output hazTimeT     useRs,
    output hazTimeT     useRt,
    output hazTimeT     newTime
);

    opcodeT  op;
    functT   fn;
    regAddrT rd;
    aluOpT   rAluOp;
    logic    fnKnown;

    assign op  = opcodeT'(instr[`OP_HI:`OP_LO]);
    assign fn  = functT'(instr[`FN_HI:`FN_LO]);
    assign rs  = instr[`RS_HI:`RS_LO];
    assign rt  = instr[`RT_HI:`RT_LO];
    assign rd  = instr[`RD_HI:`RD_LO];
    assign imm = instr[`IMM_HI:`IMM_LO];

    // R-type function map
    always_comb begin
        fnKnown = 1'b1;
        case (fn)
            fnAddu:  rAluOp = aluAdd;
            fnSubu:  rAluOp = aluSub;
            fnAnd:   rAluOp = aluAnd;
            fnOr:    rAluOp = aluOr;
            fnSlt:   rAluOp = aluSlt;
            default: begin
                rAluOp  = aluAdd;
                fnKnown = 1'b0;  // includes the all-zero nop
            end
        endcase
    end

    always_comb begin
        // default is a bubble
        dest    = '0;
        aluOp   = aluAdd;
        useImm  = 1'b0;
        wdSrc   = wdNone;
        isBeq   = 1'b0;
        isStore = 1'b0;
        useRs   = tUseNone;
        useRt   = tUseNone;
        newTime = tNewNow;
        case (op)
            opSpecial: begin
                if (fnKnown) begin
                    dest    = rd;
                    aluOp   = rAluOp;
                    wdSrc   = wdAlu;
                    useRs   = tUseAlu;
                    useRt   = tUseAlu;
                    newTime = tNewAlu;
                end
            end
            opOri: begin
                dest    = rt;
                aluOp   = aluOr;
                useImm  = 1'b1;
                wdSrc   = wdAlu;
                useRs   = tUseAlu;
                newTime = tNewAlu;
            end
            opLui: begin
                dest   = rt;
                aluOp  = aluPassB;
                useImm = 1'b1;
                wdSrc  = wdExt;  // value known in E
            end
            opLw: begin
                dest    = rt;
                useImm  = 1'b1;
                wdSrc   = wdMem;
                useRs   = tUseAlu;
                newTime = tNewLoad;
            end
            opSw: begin
                useImm  = 1'b1;
                isStore = 1'b1;
                useRs   = tUseAlu;
                useRt   = tUseStore;  // data needed only in M
            end
            opBeq: begin
                isBeq = 1'b1;
                useRs = tUseBranch;
                useRt = tUseBranch;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/memWriteback.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module memWriteback import mipsIsaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  wordT    mInstr,
    input  wordT    mPc,
    input  wordT    mAlu,
    input  wordT    mStoreData,
    input  wordT    dataRdata,
    output wordT    dataAddr,
    output wordT    dataWdata,
    output logic    dataWe,
    output regAddrT mDest,
    output hazTimeT mNew,
    output wordT    mFwdData,
    output logic    wbWe,
    output regAddrT wbAddr,
    output wordT    wbData,
    output wordT    wbPc
);

    regAddrT mRt;
    logic    mIsStore;
    hazTimeT mNewTime;
    wordT    wInstr, wAlu, wMem;
    wdSrcT   wWdSrc;

    instrDecoder mDec (
        .instr(mInstr), .rs(), .rt(mRt), .dest(mDest), .imm(), .aluOp(),
        .useImm(), .wdSrc(), .isBeq(), .isStore(mIsStore), .useRs(),
        .useRt(), .newTime(mNewTime)
    );

    // one cycle less to go than in E
    assign mNew     = (mNewTime == 2'd0) ? 2'd0 : mNewTime - 2'd1;
    assign mFwdData = mAlu;  // ALU and lui results

    ////////////////////////////////////////////////////////////
    // data bus
    ////////////////////////////////////////////////////////////
    assign dataAddr  = mAlu;
    assign dataWe    = mIsStore;
    assign dataWdata = (wbWe && mRt != '0 && mRt == wbAddr) ? wbData : mStoreData;

    // M/W register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wInstr <= `NOP_INSTR;
            wbPc   <= '0;
        end else begin
            wInstr <= mInstr;
            wbPc   <= mPc;
        end
    end

    always_ff @(posedge clk) begin
        wAlu <= mAlu;
        wMem <= dataRdata;
    end

    instrDecoder wDec (
        .instr(wInstr), .rs(), .rt(), .dest(wbAddr), .imm(), .aluOp(),
        .useImm(), .wdSrc(wWdSrc), .isBeq(), .isStore(), .useRs(),
        .useRt(), .newTime()
    );

    assign wbWe   = (wWdSrc != wdNone);
    assign wbData = (wWdSrc == wdMem) ? wMem : wAlu;

endmodule

`default_nettype wire

// ==== verilog/mips.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module mips import mipsIsaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    output wordT    instrAddr,
    input  wordT    instrData,
    output wordT    dataAddr,
    output wordT    dataWdata,
    output logic    dataWe,
    input  wordT    dataRdata,
    output logic    wbWe,
    output regAddrT wbAddr,
    output wordT    wbData,
    output wordT    wbPc
);

    logic    stall, branchTaken;
    wordT    branchTarget, dInstr, dPc, rdDataA, rdDataB;
    wordT    mInstr, mPc, mAlu, mStoreData, mFwdData, wFwdData;
    regAddrT dRs, dRt, eRs, eRt, eDest, mDest;
    hazTimeT dUseRs, dUseRt, eNew, mNew;
    fwdSelT  dFwdRs, dFwdRt, eFwdRs, eFwdRt;

    assign wFwdData = wbData;  // W value feeds back to the E muxes

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////
    fetchStage fetch (.*);

    ////////////////////////////////////////////////////////////
    // processing
    ////////////////////////////////////////////////////////////
    regFile grf (
        .clk(clk), .rstN(rstN), .rdAddrA(dRs), .rdAddrB(dRt),
        .wrAddr(wbAddr), .wrEn(wbWe), .wrData(wbData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    hazardUnit hazard (.wDest(wbAddr), .*);

    executeStage exec (.*);

    ////////////////////////////////////////////////////////////
    // output side
    ////////////////////////////////////////////////////////////
    memWriteback memWb (.*);

endmodule

`default_nettype wire

// ==== verilog/mipsIsaPkg.sv ====
`default_nettype none
`include "mips_consts.svh"

package mipsIsaPkg;

    typedef logic [`WORD_W-1:0] wordT;
    typedef logic [`REG_AW-1:0] regAddrT;

    // primary opcode field
    typedef enum logic [5:0] {
        opSpecial = 6'h00,  // R-type, see funct
        opBeq     = 6'h04,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // funct field of opSpecial
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,   // signed compare
        aluPassB  // lui goes through here
    } aluOpT;

endpackage

`default_nettype wire

// ==== verilog/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define WORD_W    32            // data and address width
`define REG_AW    5             // register number width
`define RESET_PC  32'h0000_3000 // first fetch address
`define NOP_INSTR 32'h0000_0000 // bubble, decodes as no write

// instruction field positions
`define OP_HI  31
`define OP_LO  26
`define RS_HI  25
`define RS_LO  21
`define RT_HI  20
`define RT_LO  16
`define RD_HI  15
`define RD_LO  11
`define FN_HI  5
`define FN_LO  0
`define IMM_HI 15
`define IMM_LO 0

`endif

// ==== verilog/pipePkg.sv ====
`default_nettype none
`include "mips_consts.svh"

package pipePkg;

    // where the written value comes from, wdNone means no write
    typedef enum logic [1:0] {
        wdNone = 2'd0,
        wdAlu  = 2'd1,
        wdMem  = 2'd2,
        wdExt  = 2'd3   // ready already in E
    } wdSrcT;

    typedef enum logic [1:0] {
        fwdReg   = 2'd0,  // register file value
        fwdFromE = 2'd1,
        fwdFromM = 2'd2,
        fwdFromW = 2'd3
    } fwdSelT;

    typedef logic [1:0] hazTimeT;

    ////////////////////////////////////////////////////////////
    // use times, cycles until the operand is needed
    ////////////////////////////////////////////////////////////
    localparam hazTimeT tUseBranch = 2'd0;
    localparam hazTimeT tUseAlu    = 2'd1;
    localparam hazTimeT tUseStore  = 2'd2;
    localparam hazTimeT tUseNone   = 2'd3;  // never stalls

    // new times, counted from the E stage
    localparam hazTimeT tNewNow  = 2'd0;
    localparam hazTimeT tNewAlu  = 2'd1;
    localparam hazTimeT tNewLoad = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_consts.svh"

module regFile import mipsIsaPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT rdAddrA,
    input  regAddrT rdAddrB,
    input  regAddrT wrAddr,
    input  logic    wrEn,
    input  wordT    wrData,
    output wordT    rdDataA,
    output wordT    rdDataB
);

    localparam int NumRegs = 1 << `REG_AW;

    wordT regs [1:NumRegs-1];  // $0 is not stored

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // W write in the same cycle shows up on the read ports
    always_comb begin
        if (rdAddrA == '0)                     rdDataA = '0;
        else if (wrEn && wrAddr == rdAddrA)    rdDataA = wrData;
        else                                   rdDataA = regs[rdAddrA];

        if (rdAddrB == '0)                     rdDataB = '0;
        else if (wrEn && wrAddr == rdAddrB)    rdDataB = wrData;
        else                                   rdDataB = regs[rdAddrB];
    end

endmodule

`default_nettype wire
